//--- files.f
+incdir+logic
logic/ks10Pkg.sv
logic/consoleIntf.sv
logic/piCtl.sv
logic/execUnit.sv
logic/busIntf.sv
logic/cpu.sv
verif/cpu_checker.sv
verif/cpuTb.sv

//--- Makefile
# Verilator build and run for the KS10 CPU slice

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG ERR_LIMIT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) | tee $(LOG)
	@if grep -q "Simulation completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/cpuTb.sv
`include "ks10_consts.svh"

module cpuTb;

   localparam int numTests  = 6;
   localparam int testLimit = 500;                // Worst case per test incl. reset
   localparam int maxCycles = numTests * testLimit;

   logic               clkT = 1'b0;
   logic               rstN, cslSet, cslRun, cslCont, cslExec;
   logic [1:7]         ubaIntr;
   logic               cpuAck = 1'b0;             // Driven by memory model
   logic [`WORD_W-1:0] cpuDataIn = '0;
   logic               cpuReq, cpuNxm, cpuHalt;
   ks10Pkg::busReqT    cpuBus;
   ks10Pkg::consoleT   cpuCsl;

   logic [`WORD_W-1:0] mem [0:(1 << `ADDR_W) - 1];
   ks10Pkg::busReqT    reqLog[$];                 // Every request seen, in order
   ks10Pkg::busReqT    expReq[$];
   logic               reqSeen = 1'b0;
   logic               holdAck = 1'b0;            // Withhold ack for NXM
   int                 waitLeft = 0;
   integer             seed = 46;
   int                 errCount = 0, checkCount = 0, testsRun = 0, cycles = 0;

   cpu dut0 (.clkT(clkT), .rstN(rstN), .cslSet(cslSet), .cslRun(cslRun), .cslCont(cslCont),
      .cslExec(cslExec), .ubaIntr(ubaIntr), .cpuAck(cpuAck), .cpuDataIn(cpuDataIn),
      .cpuReq(cpuReq), .cpuBus(cpuBus), .cpuNxm(cpuNxm), .cpuHalt(cpuHalt), .cpuCsl(cpuCsl));

   always #50 clkT = ~clkT;

   always @(posedge clkT) begin
      cycles <= cycles + 1;
      if (cycles == maxCycles) begin
         $display("run stopped after %0d cycles, a test never finished", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Memory model
   ////////////////////////////////////////////////////////////

   always @(posedge clkT) begin
      cpuAck <= 1'b0;
      if (!rstN || !cpuReq || cpuAck) begin
         reqSeen <= 1'b0;                         // Idle or just acked
      end else if (!reqSeen) begin
         reqSeen  <= 1'b1;
         reqLog.push_back(cpuBus);
         waitLeft <= $unsigned($random(seed)) % 4;  // 1 to 4 cycles
      end else if (waitLeft != 0) begin
         waitLeft <= waitLeft - 1;
      end else if (!holdAck) begin
         cpuAck    <= 1'b1;
         cpuDataIn <= mem[cpuBus.addr];           // Writes are only logged
      end
   end

   function automatic logic [`WORD_W-1:0] instr(input ks10Pkg::opcodeT op,
                                                input logic [`ADDR_W-1:0] ea);
      return {op, 9'b0, ea};                      // AC, I and X fields zero
   endfunction

   function automatic ks10Pkg::busReqT readReq(input logic [`ADDR_W-1:0] addr);
      ks10Pkg::busReqT r;
      r      = '0;
      r.addr = addr;
      return r;
   endfunction

   task automatic checkBus(input string name, input ks10Pkg::busReqT got,
                           input ks10Pkg::busReqT exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkCsl(input string name, input ks10Pkg::consoleT got,
                           input ks10Pkg::consoleT exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   // Log from index 'from' against expReq
   task automatic compareLog(input int from);
      int n;
      n = reqLog.size() - from;
      checkCount++;
      if (n != expReq.size()) begin
         errCount++;
         $display("saw %0d bus requests where %0d were expected", n, expReq.size());
      end
      for (int i = 0; i < expReq.size() && i < n; i++) begin
         checkBus($sformatf("cpuBus[%0d]", i), reqLog[from + i], expReq[i]);
      end
   endtask

   task automatic waitHalt(input logic level, input int limit, input string what);
      int n;
      n = 0;
      @(negedge clkT);
      while (cpuHalt !== level && n < limit) begin
         @(negedge clkT);
         n++;
      end
      if (cpuHalt !== level) begin
         errCount++;
         $display("%s did not happen within %0d cycles", what, limit);
      end
   endtask

   task automatic waitFetch(input logic [`ADDR_W-1:0] addr, input int limit);
      int n;
      n = 0;
      while (!(cpuReq && cpuBus.addr == addr) && n < limit) begin
         @(negedge clkT);
         n++;
      end
      if (n == limit) begin
         errCount++;
         $display("no request to address %o within %0d cycles", addr, limit);
      end
   endtask

   task automatic setConsole(input logic run, input logic cont, input logic exec);
      @(posedge clkT);
      cslSet  <= 1'b1;
      cslRun  <= run;
      cslCont <= cont;
      cslExec <= exec;
      @(posedge clkT);
      cslSet  <= 1'b0;
   endtask

   task automatic applyReset();
      @(posedge clkT);
      rstN    <= 1'b0;
      ubaIntr <= '0;
      repeat (10) @(posedge clkT);
      rstN    <= 1'b1;
   endtask

   task automatic endTest(input string name, input int errBefore);
      testsRun++;
      if (errCount == errBefore) begin
         $display("test %s passed", name);
      end else begin
         $display("test %s failed with %0d errors", name, errCount - errBefore);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic resetState();
      int errBefore;
      ks10Pkg::consoleT expCsl;
      errBefore = errCount;
      @(negedge clkT);
      checkFlag("cpuHalt", cpuHalt, 1'b1);
      checkFlag("cpuReq", cpuReq, 1'b0);
      checkFlag("cpuNxm", cpuNxm, 1'b0);
      checkCsl("cpuCsl", cpuCsl, '0);
      setConsole(1'b1, 1'b0, 1'b1);               // No cont so nothing starts
      expCsl      = '0;
      expCsl.run  = 1'b1;
      expCsl.exec = 1'b1;
      @(negedge clkT);
      checkCsl("cpuCsl", cpuCsl, expCsl);
      setConsole(1'b0, 1'b0, 1'b0);
      endTest("resetState", errBefore);
   endtask

   task automatic runProgram();
      int errBefore, mark;
      ks10Pkg::busReqT wr;
      errBefore = errCount;
      applyReset();
      mem[`START_ADDR]     = instr(ks10Pkg::opMovei, 18'd5);
      mem[`START_ADDR + 1] = instr(ks10Pkg::opAdd, 18'o1100);
      mem[`START_ADDR + 2] = instr(ks10Pkg::opMovem, 18'o2000);
      mem[`START_ADDR + 3] = instr(ks10Pkg::opHalt, 18'd0);
      mem[18'o1100]        = 36'd7;
      wr       = readReq(18'o2000);
      wr.write = 1'b1;
      wr.data  = 36'd5 + 36'd7;
      expReq = {readReq(`START_ADDR), readReq(`START_ADDR + 1), readReq(18'o1100),
                readReq(`START_ADDR + 2), wr, readReq(`START_ADDR + 3)};
      mark = reqLog.size();
      setConsole(1'b1, 1'b1, 1'b0);
      waitHalt(1'b0, 10, "start");
      waitHalt(1'b1, 200, "program halt");
      compareLog(mark);
      checkFlag("cpuHalt", cpuHalt, 1'b1);
      endTest("runProgram", errBefore);
   endtask

   task automatic singleStep();
      int errBefore, mark;
      ks10Pkg::consoleT expCsl;
      errBefore = errCount;
      applyReset();
      mem[`START_ADDR]     = instr(ks10Pkg::opMovei, 18'd1);
      mem[`START_ADDR + 1] = instr(ks10Pkg::opMovei, 18'd2);
      mark = reqLog.size();
      setConsole(1'b0, 1'b1, 1'b1);
      waitHalt(1'b0, 10, "first step start");
      waitHalt(1'b1, 100, "first step halt");
      expReq = {readReq(`START_ADDR)};
      compareLog(mark);
      expCsl      = '0;
      expCsl.exec = 1'b1;                         // Cont consumed
      checkCsl("cpuCsl", cpuCsl, expCsl);
      setConsole(1'b0, 1'b1, 1'b1);
      waitHalt(1'b0, 10, "second step start");
      waitHalt(1'b1, 100, "second step halt");
      expReq.push_back(readReq(`START_ADDR + 1));
      compareLog(mark);
      endTest("singleStep", errBefore);
   endtask

   task automatic stopAtBoundary();
      int errBefore, mark, last;
      errBefore = errCount;
      applyReset();
      mem[`START_ADDR] = instr(ks10Pkg::opJrst, `START_ADDR);
      mark = reqLog.size();
      setConsole(1'b1, 1'b1, 1'b0);
      repeat (40) @(negedge clkT);
      checkFlag("loopRunning", reqLog.size() - mark >= 2, 1'b1);
      setConsole(1'b0, 1'b0, 1'b0);
      waitHalt(1'b1, 100, "halt after run cleared");
      for (int i = mark; i < reqLog.size(); i++) begin
         checkBus("cpuBus", reqLog[i], readReq(`START_ADDR));
      end
      last = reqLog.size();
      repeat (20) @(negedge clkT);
      checkFlag("reqAfterHalt", reqLog.size() != last, 1'b0);
      checkFlag("cpuHalt", cpuHalt, 1'b1);
      endTest("stopAtBoundary", errBefore);
   endtask

   task automatic nxmTimeout();
      int errBefore, n;
      errBefore = errCount;
      applyReset();
      holdAck = 1'b1;
      setConsole(1'b1, 1'b1, 1'b0);
      waitFetch(`START_ADDR, 20);
      n = 0;
      while (!cpuNxm && n < 4 * `NXM_TIMEOUT) begin
         @(negedge clkT);
         n++;
      end
      if (n != `NXM_TIMEOUT) begin
         errCount++;
         $display("cpuNxm came %0d cycles after cpuReq, expected %0d", n, `NXM_TIMEOUT);
      end
      waitHalt(1'b1, 10, "halt after NXM");
      checkFlag("cpuNxm", cpuNxm, 1'b1);
      checkFlag("cpuReq", cpuReq, 1'b0);
      checkFlag("cpuHalt", cpuHalt, 1'b1);
      holdAck = 1'b0;
      endTest("nxmTimeout", errBefore);
   endtask

   task automatic interruptPriority();
      int errBefore, first;
      logic [`ADDR_W-1:0] vec3, vec5;
      errBefore = errCount;
      vec3 = `PI_VEC_BASE + 2 * 3;
      vec5 = `PI_VEC_BASE + 2 * 5;
      applyReset();
      mem[`START_ADDR] = instr(ks10Pkg::opJrst, `START_ADDR);
      mem[vec3]        = instr(ks10Pkg::opJen, 18'd0);
      mem[vec5]        = instr(ks10Pkg::opHalt, 18'd0);
      setConsole(1'b1, 1'b1, 1'b0);
      repeat (20) @(negedge clkT);                // Loop under way
      first = reqLog.size();
      @(posedge clkT);
      ubaIntr[3] <= 1'b1;
      ubaIntr[5] <= 1'b1;
      waitFetch(vec3, 100);
      @(posedge clkT);
      ubaIntr[3] <= 1'b0;                         // Level 3 serviced
      @(negedge clkT);
      waitFetch(vec5, 200);
      @(posedge clkT);
      ubaIntr[5] <= 1'b0;
      waitHalt(1'b1, 100, "halt at level 5 vector");
      // One loop fetch may already be in flight
      if (reqLog.size() > first && reqLog[first].addr == `START_ADDR) begin
         first++;
      end
      expReq = {readReq(vec3), readReq(`START_ADDR), readReq(vec5)};
      compareLog(first);
      endTest("interruptPriority", errBefore);
   endtask

   initial begin
      rstN      = 1'b0;
      cslSet    = 1'b0;
      cslRun    = 1'b0;
      cslCont   = 1'b0;
      cslExec   = 1'b0;
      ubaIntr   = '0;
      for (int a = 0; a < (1 << `ADDR_W); a++) begin
         mem[a] = {18'(a) ^ 18'o252525, 18'(a)};  // Pattern from the whole address
      end
      repeat (10) @(posedge clkT);
      rstN <= 1'b1;
      resetState();
      runProgram();
      singleStep();
      stopAtBoundary();
      nxmTimeout();
      interruptPriority();
      @(negedge clkT);
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
               testsRun, checkCount, errCount, dut0.checker0.failCount);
      if (errCount == 0 && dut0.checker0.failCount == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- verif/cpu_checker.sv
`include "ks10_consts.svh"

module cpuChecker (
   input logic            clkT,
   input logic            rstN,
   input logic            cpuReq,     // From busIntf
   input logic            cpuAck,
   input ks10Pkg::busReqT cpuBus,     // From busIntf
   input logic            cpuNxm,     // From busIntf
   input logic            cpuHalt     // From execUnit
);

   int unsigned waitCycles;           // Edges with cpuReq up and no ack
   int unsigned failCount = 0;        // Read by the testbench at the end

   always @(posedge clkT) begin
      if (!rstN || !cpuReq || cpuAck) begin
         waitCycles <= 0;
      end else begin
         waitCycles <= waitCycles + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Bus and halt rules
   ////////////////////////////////////////////////////////////

   reqHeld: assert property (@(posedge clkT) disable iff (!rstN)
      cpuReq && !cpuAck |=> (cpuReq && $stable(cpuBus)) || $rose(cpuNxm))
      else begin failCount++; $error("cpuReq or cpuBus moved before ack"); end

   // Requests only while running
   noReqHalted: assert property (@(posedge clkT) disable iff (!rstN)
      $rose(cpuReq) |-> !cpuHalt)
      else begin failCount++; $error("cpuReq rose with cpuHalt high"); end

   nxmOnTime: assert property (@(posedge clkT) disable iff (!rstN)
      cpuReq && !cpuAck && waitCycles == `NXM_TIMEOUT - 1 |=> $rose(cpuNxm))
      else begin failCount++; $error("cpuNxm missing after timeout"); end

   nxmNotEarly: assert property (@(posedge clkT) disable iff (!rstN)
      $rose(cpuNxm) |-> $past(cpuReq && !cpuAck && waitCycles == `NXM_TIMEOUT - 1))
      else begin failCount++; $error("cpuNxm set at the wrong cycle"); end

endmodule

// Top level is where busIntf and execUnit signals meet
bind cpu cpuChecker checker0 (.clkT(clkT), .rstN(rstN), .cpuReq(cpuReq), .cpuAck(cpuAck),
   .cpuBus(cpuBus), .cpuNxm(cpuNxm), .cpuHalt(cpuHalt));

//--- logic/cpu.sv
`include "ks10_consts.svh"

module cpu (
   input  logic               clkT,       // Clock
   input  logic               rstN,       // Sync reset, active low
   input  logic               cslSet,     // Console load strobe
   input  logic               cslRun,     // Console run level
   input  logic               cslCont,    // Console continue level
   input  logic               cslExec,    // Console execute level
   input  logic [1:7]         ubaIntr,    // Unibus interrupt requests
   input  logic               cpuAck,     // Memory acknowledge
   input  logic [`WORD_W-1:0] cpuDataIn,  // Memory read data
   output logic               cpuReq,     // Bus request
   output ks10Pkg::busReqT    cpuBus,     // Address, write, data
   output logic               cpuNxm,     // Non-existent memory seen
   output logic               cpuHalt,    // Halted
   output ks10Pkg::consoleT   cpuCsl      // Console flag status
);

   logic               contTaken;
   logic               piIntr;
   ks10Pkg::piLevelT   piReqLevel;
   logic               piTake;
   logic               piDismiss;
   logic               busStart;
   ks10Pkg::busReqT    busReq;
   logic               busDone;
   logic               busNxm;
   logic [`WORD_W-1:0] busData;

   consoleIntf uConsoleIntf (.clkT(clkT), .rstN(rstN), .cslSet(cslSet), .cslRun(cslRun),
      .cslCont(cslCont), .cslExec(cslExec), .contTaken(contTaken), .cpuCsl(cpuCsl));

   piCtl uPiCtl (.clkT(clkT), .rstN(rstN), .ubaIntr(ubaIntr), .piTake(piTake),
      .piDismiss(piDismiss), .piIntr(piIntr), .piReqLevel(piReqLevel));

   execUnit uExecUnit (.clkT(clkT), .rstN(rstN), .cpuCsl(cpuCsl), .contTaken(contTaken),
      .piIntr(piIntr), .piReqLevel(piReqLevel), .piTake(piTake), .piDismiss(piDismiss),
      .busStart(busStart), .busReq(busReq), .busDone(busDone), .busNxm(busNxm),
      .busData(busData), .cpuHalt(cpuHalt));

   busIntf uBusIntf (.clkT(clkT), .rstN(rstN), .busStart(busStart), .busReq(busReq),
      .cpuAck(cpuAck), .cpuDataIn(cpuDataIn), .busDone(busDone), .busNxm(busNxm),
      .busData(busData), .cpuReq(cpuReq), .cpuBus(cpuBus), .cpuNxm(cpuNxm));

endmodule

//--- logic/busIntf.sv
`include "ks10_consts.svh"

module busIntf (
   input  logic               clkT,       // Clock
   input  logic               rstN,       // Sync reset, active low
   input  logic               busStart,   // New cycle from execUnit
   input  ks10Pkg::busReqT    busReq,     // Cycle address and data
   input  logic               cpuAck,     // Memory acknowledge pulse
   input  logic [`WORD_W-1:0] cpuDataIn,  // Read data, valid with ack
   output logic               busDone,    // Cycle complete
   output logic               busNxm,     // Cycle timed out
   output logic [`WORD_W-1:0] busData,    // Captured read data
   output logic               cpuReq,     // Bus request level
   output ks10Pkg::busReqT    cpuBus,     // Held request
   output logic               cpuNxm      // Sticky NXM status
);

   localparam int cntW = $clog2(`NXM_TIMEOUT);
   localparam logic [cntW-1:0] cntLast = cntW'(`NXM_TIMEOUT - 1);

   logic [cntW-1:0] waitCnt;              // Cycles cpuReq has been up
   logic            timeout;

   // Last waiting cycle and still no ack
   assign timeout = cpuReq && !cpuAck && waitCnt == cntLast;

   ////////////////////////////////////////////////////////////
   // Request and NXM control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clkT) begin
      if (!rstN) begin
         cpuReq  <= 1'b0;
         busDone <= 1'b0;
         busNxm  <= 1'b0;
         cpuNxm  <= 1'b0;
         waitCnt <= '0;
      end else begin
         busDone <= cpuReq && cpuAck;     // One cycle after ack
         busNxm  <= timeout;
         if (timeout) begin
            cpuNxm <= 1'b1;               // Held until reset
         end
         if (busStart) begin
            cpuReq  <= 1'b1;              // Rises the cycle after start
            waitCnt <= '0;
         end else if (cpuAck || timeout) begin
            cpuReq  <= 1'b0;              // Done or abandoned
         end else if (cpuReq) begin
            waitCnt <= waitCnt + 1'b1;
         end
      end
   end

   // Request register and read return
   always_ff @(posedge clkT) begin
      if (busStart) begin
         cpuBus <= busReq;                // Stable for the whole cycle
      end
      if (cpuReq && cpuAck) begin
         busData <= cpuDataIn;
      end
   end

endmodule

//--- logic/execUnit.sv
`include "ks10_consts.svh"

module execUnit (
   input  logic               clkT,        // Clock
   input  logic               rstN,        // Sync reset, active low
   input  ks10Pkg::consoleT   cpuCsl,      // Console flags
   output logic               contTaken,   // Leaving halt
   input  logic               piIntr,      // Interrupt pending
   input  ks10Pkg::piLevelT   piReqLevel,  // Pending level
   output logic               piTake,      // Accept pending level
   output logic               piDismiss,   // Clear active level
   output logic               busStart,    // Start bus cycle
   output ks10Pkg::busReqT    busReq,      // Cycle address and data
   input  logic               busDone,     // Cycle finished
   input  logic               busNxm,      // Cycle timed out
   input  logic [`WORD_W-1:0] busData,     // Read data
   output logic               cpuHalt      // Halted status
);

   ks10Pkg::execStateT state;
   ks10Pkg::execStateT nextState;
   ks10Pkg::execStateT bndState;           // Exit from an instruction boundary
   ks10Pkg::opcodeT    opcode;
   ks10Pkg::piLevelT   intrLevel;          // Level being vectored
   logic [`ADDR_W-1:0] pc;
   logic [`ADDR_W-1:0] savedPc;            // Interrupt return address
   logic [`ADDR_W-1:0] ea;                 // Effective address
   logic [`WORD_W-1:0] ac;                 // Accumulator
   logic [`WORD_W-1:0] ir;                 // Instruction register
   logic               busIssued;          // Current cycle already started
   logic               busState;

   assign opcode = ks10Pkg::opcodeT'(ir[`WORD_W-1:`WORD_W-9]);
   assign ea     = ir[`ADDR_W-1:0];

   ////////////////////////////////////////////////////////////
   // Sequencing
   ////////////////////////////////////////////////////////////

   // Boundary: halt first, then interrupts, then next fetch
   always_comb begin
      if (!cpuCsl.run || cpuCsl.exec) begin
         bndState = ks10Pkg::stHalted;     // Stop or single step done
      end else if (piIntr) begin
         bndState = ks10Pkg::stIntr;
      end else begin
         bndState = ks10Pkg::stFetch;
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         ks10Pkg::stHalted: begin
            if (cpuCsl.cont && piIntr) begin
               nextState = ks10Pkg::stIntr;
            end else if (cpuCsl.cont) begin
               nextState = ks10Pkg::stFetch;
            end
         end
         ks10Pkg::stFetch: begin
            if (busNxm) begin
               nextState = ks10Pkg::stHalted;
            end else if (busDone) begin
               nextState = ks10Pkg::stDecode;
            end
         end
         ks10Pkg::stDecode: begin
            case (opcode)
               ks10Pkg::opMove, ks10Pkg::opAdd: nextState = ks10Pkg::stOperand;
               ks10Pkg::opMovem:                nextState = ks10Pkg::stStore;
               ks10Pkg::opMovei, ks10Pkg::opJrst, ks10Pkg::opJen: nextState = bndState;
               default:                         nextState = ks10Pkg::stHalted; // HALT too
            endcase
         end
         ks10Pkg::stOperand, ks10Pkg::stStore: begin
            if (busNxm) begin
               nextState = ks10Pkg::stHalted;
            end else if (busDone) begin
               nextState = bndState;
            end
         end
         ks10Pkg::stIntr: nextState = ks10Pkg::stFetch;  // Fetch at vector
         default:         nextState = ks10Pkg::stHalted;
      endcase
   end

   // Status and handshake pulses
   assign cpuHalt   = state == ks10Pkg::stHalted;
   assign contTaken = cpuHalt && cpuCsl.cont;
   assign piTake    = nextState == ks10Pkg::stIntr;    // Only entered for one cycle
   assign piDismiss = state == ks10Pkg::stDecode && opcode == ks10Pkg::opJen;

   ////////////////////////////////////////////////////////////
   // Bus requests
   ////////////////////////////////////////////////////////////

   assign busState = state == ks10Pkg::stFetch || state == ks10Pkg::stOperand ||
                     state == ks10Pkg::stStore;
   assign busStart = busState && !busIssued;          // First cycle of a bus state

   always_comb begin
      busReq      = '0;
      busReq.addr = pc;                               // Fetch by default
      if (state == ks10Pkg::stOperand) begin
         busReq.addr = ea;
      end else if (state == ks10Pkg::stStore) begin
         busReq.addr  = ea;
         busReq.write = 1'b1;
         busReq.data  = ac;
      end
   end

   ////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clkT) begin
      if (!rstN) begin
         state     <= ks10Pkg::stHalted;
         pc        <= `START_ADDR;
         busIssued <= 1'b0;
      end else begin
         state <= nextState;
         if (busStart) begin
            busIssued <= 1'b1;
         end else if (busDone || busNxm) begin
            busIssued <= 1'b0;                        // Ready for next cycle
         end
         if (state == ks10Pkg::stFetch && busDone) begin
            pc <= pc + 1'b1;                          // Next sequential
         end else if (piDismiss) begin
            pc <= savedPc;                            // Back to interrupted code
         end else if (state == ks10Pkg::stDecode && opcode == ks10Pkg::opJrst) begin
            pc <= ea;
         end else if (state == ks10Pkg::stIntr) begin
            pc <= `PI_VEC_BASE + {{(`ADDR_W-4){1'b0}}, intrLevel, 1'b0};
         end
      end
   end

   // Datapath registers
   always_ff @(posedge clkT) begin
      if (state == ks10Pkg::stFetch && busDone) begin
         ir <= busData;
      end
      if (state == ks10Pkg::stDecode && opcode == ks10Pkg::opMovei) begin
         ac <= {{(`WORD_W-`ADDR_W){1'b0}}, ea};       // Zero extended
      end else if (state == ks10Pkg::stOperand && busDone) begin
         if (opcode == ks10Pkg::opMove) begin
            ac <= busData;
         end else begin
            ac <= ac + busData;                       // Wraps mod 2**36
         end
      end
      if (piTake) begin
         intrLevel <= piReqLevel;
      end
      if (state == ks10Pkg::stIntr) begin
         savedPc <= pc;                               // Already points past last insn
      end
   end

endmodule

//--- logic/piCtl.sv
module piCtl (
   input  logic             clkT,        // Clock
   input  logic             rstN,        // Sync reset, active low
   input  logic [1:7]       ubaIntr,     // Request per level, bit n is level n
   input  logic             piTake,      // Requested level accepted
   input  logic             piDismiss,   // JEN executed
   output logic             piIntr,      // Interrupt pending
   output ks10Pkg::piLevelT piReqLevel   // Highest requested level
);

   logic [1:7]       inProg;             // Levels being serviced
   ks10Pkg::piLevelT curLevel;           // Highest level in progress

   // Highest priority set bit, lowest index wins
   function automatic ks10Pkg::piLevelT highest(input logic [1:7] v);
      ks10Pkg::piLevelT lvl;
      lvl = '0;                          // None
      for (int i = 7; i >= 1; i--) begin
         if (v[i]) begin
            lvl = 3'(i);
         end
      end
      return lvl;
   endfunction

   ////////////////////////////////////////////////////////////
   // Priority encoders
   ////////////////////////////////////////////////////////////

   assign piReqLevel = highest(ubaIntr);
   assign curLevel   = highest(inProg);

   // Request must strictly outrank everything in progress
   // Smaller number is higher priority
   always_comb begin
      if (piReqLevel == '0) begin
         piIntr = 1'b0;                  // Nothing requested
      end else if (curLevel == '0) begin
         piIntr = 1'b1;                  // Idle, any level goes
      end else begin
         piIntr = piReqLevel < curLevel;
      end
   end

   ////////////////////////////////////////////////////////////
   // In-progress register
   ////////////////////////////////////////////////////////////

   // Take sets the requested level
   // Dismiss clears only the highest active level
   always_ff @(posedge clkT) begin
      if (!rstN) begin
         inProg <= '0;
      end else begin
         for (int i = 1; i <= 7; i++) begin
            if (piTake && piReqLevel == 3'(i)) begin
               inProg[i] <= 1'b1;
            end else if (piDismiss && curLevel == 3'(i)) begin
               inProg[i] <= 1'b0;
            end
         end
      end
   end

endmodule

//--- logic/consoleIntf.sv
module consoleIntf (
   input  logic             clkT,      // Clock
   input  logic             rstN,      // Sync reset, active low
   input  logic             cslSet,    // Load strobe
   input  logic             cslRun,    // Run level
   input  logic             cslCont,   // Continue level
   input  logic             cslExec,   // Execute level
   input  logic             contTaken, // CPU left halt
   output ks10Pkg::consoleT cpuCsl     // Flag register
);

   ////////////////////////////////////////////////////////////
   // Console flag register
   ////////////////////////////////////////////////////////////

   // The console drives run, cont and exec as levels and
   // qualifies them with a single cslSet strobe

   // Cont is a one-shot request
   // It stays up until the CPU actually leaves halt
   // Run and exec are left alone by the CPU

   always_ff @(posedge clkT) begin
      if (!rstN) begin
         cpuCsl <= '0;                  // Console idle
      end else if (cslSet) begin
         // Strobe wins over contTaken
         cpuCsl.run  <= cslRun;
         cpuCsl.cont <= cslCont;
         cpuCsl.exec <= cslExec;
      end else if (contTaken) begin
         cpuCsl.cont <= 1'b0;           // Request consumed
      end
   end

   // Flags go out to the top level too
   // They double as the CPU status the console reads back

   // Typical sequences
   //   run + cont      free running program
   //   exec + cont     one instruction then halt
   //   run cleared     halt at next boundary

   // Nothing here looks at cpuHalt
   // The execution unit decides when cont is taken

   // Note that a cont strobe while already running
   // sits until the next halt, then restarts the CPU

endmodule

//--- logic/ks10Pkg.sv
`include "ks10_consts.svh"

package ks10Pkg;

   // Opcodes, anything else halts
   typedef enum logic [8:0] {
      opMove  = `OP_MOVE,        // AC from memory
      opMovei = `OP_MOVEI,       // AC from effective address
      opMovem = `OP_MOVEM,       // AC to memory
      opAdd   = `OP_ADD,         // AC plus memory
      opJrst  = `OP_JRST,        // Jump
      opJen   = `OP_JEN,         // Dismiss and return
      opHalt  = `OP_HALT         // Stop
   } opcodeT;

   // Execution states
   typedef enum logic [2:0] {
      stHalted,                  // Waiting on console cont
      stFetch,                   // Instruction read in flight
      stDecode,                  // Opcode dispatch
      stOperand,                 // Operand read in flight
      stStore,                   // AC write in flight
      stIntr                     // Vector to interrupt handler
   } execStateT;

   ////////////////////////////////////////////////////////////
   // Bus request
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [`ADDR_W-1:0] addr;  // Word address
      logic               write; // 1 for write cycle
      logic [`WORD_W-1:0] data;  // Write data
   } busReqT;

   // Console status flags
   typedef struct packed {
      logic run;                 // Keep running
      logic cont;                // Leave halt
      logic exec;                // Single instruction
   } consoleT;

   // Interrupt level, 1 highest, 0 none
   typedef logic [2:0] piLevelT;

endpackage

//--- logic/ks10_consts.svh
`ifndef KS10_CONSTS_SVH
`define KS10_CONSTS_SVH

// Datapath widths
`define WORD_W 36                // PDP-10 word
`define ADDR_W 18                // Halfword address

// Cycles a request may sit unacknowledged
`define NXM_TIMEOUT 16

// PC after reset
`define START_ADDR 18'o1000

// Interrupt vectors sit at base plus twice the level
`define PI_VEC_BASE 18'o40

// Opcode field codes, bits 35 to 27
`define OP_MOVE  9'o200
`define OP_MOVEI 9'o201
`define OP_MOVEM 9'o202
`define OP_ADD   9'o270
`define OP_JRST  9'o254
`define OP_JEN   9'o255
`define OP_HALT  9'o256

`endif
